// ==== hdl/mul_types_pkg.sv ====
package mul_types_pkg;

    // operand and product widths
    localparam int operand_w = 8;
    localparam int product_w = 2 * operand_w;

    // one multiplier operand
    typedef logic [operand_w-1:0] operand_t;

    // multiplicand gated by one multiplier bit
    typedef logic [operand_w-1:0] pp_row_t;

    // full unsigned product
    typedef logic [product_w-1:0] product_t;

endpackage

// ==== hdl/mul_hs_pkg.sv ====
package mul_hs_pkg;

    // four-phase req/ack sequencing
    typedef enum logic [1:0] {
        hs_idle    = 2'd0, // waiting for req
        hs_compute = 2'd1, // operands held, tree settling
        hs_done    = 2'd2, // ack high, product valid
        hs_release = 2'd3  // ack dropped, one cycle gap
    } hs_state_t;

endpackage

// ==== hdl/kogge_stone_adder.sv ====
`timescale 1ns/100ps

module kogge_stone_adder #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] in1,
    input  logic [WIDTH-1:0] in2,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    // prefix levels for WIDTH of 2 or more
    localparam int LEVELS = $clog2(WIDTH);

    // group generate per level with level 0 per bit
    wire [WIDTH-1:0] g_lvl [0:LEVELS];
    // group propagate where a black cell still needs it
    wire [WIDTH-1:0] p_lvl [0:LEVELS-1];
    wire [WIDTH-1:0] carry;

    assign g_lvl[0] = in1 & in2;
    assign p_lvl[0] = in1 ^ in2;

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int DIST = 1 << l;

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (i < DIST) begin : g_pass
                // already resolved down to bit 0
                assign g_lvl[l+1][i] = g_lvl[l][i];
            end else if (i < 2 * DIST) begin : g_gray
                // group reaches bit 0 so only generate is needed
                assign g_lvl[l+1][i] = g_lvl[l][i] | (p_lvl[l][i] & g_lvl[l][i-DIST]);
            end else begin : g_black
                assign g_lvl[l+1][i] = g_lvl[l][i] | (p_lvl[l][i] & g_lvl[l][i-DIST]);
                assign p_lvl[l+1][i] = p_lvl[l][i] & p_lvl[l][i-DIST];
            end
        end
    end

    // carry into bit i is the group generate of bits i-1..0 with cin zero
    assign carry = {g_lvl[LEVELS][WIDTH-2:0], 1'b0};

    assign sum  = p_lvl[0] ^ carry;
    assign cout = g_lvl[LEVELS][WIDTH-1];

endmodule

// ==== hdl/partial_product_tree.sv ====
`timescale 1ns/100ps

module partial_product_tree
    import mul_types_pkg::*;
(
    input  operand_t op_a,
    input  operand_t op_b,
    output product_t product_comb
);

    pp_row_t pp [operand_w];

    // and array, row r has weight r
    for (genvar r = 0; r < operand_w; r++) begin : g_row
        assign pp[r] = op_b & {operand_w{op_a[r]}};
    end

    // stage 1, bit k has weight k+2
    logic [10:0] s0, in0_1, in0_2;
    logic        c0;

    assign in0_1 = {pp[7][5:0], pp[6][0], pp[5][0], pp[4][0], pp[3][0], pp[2][0]};
    assign in0_2 = {pp[6][6:1], pp[5][1], pp[4][1], pp[3][1], pp[2][1], pp[1][1]};

    kogge_stone_adder #(.WIDTH(11)) ks0_i (
        .in1  (in0_1),
        .in2  (in0_2),
        .sum  (s0),
        .cout (c0)
    );

    // stage 2, weight k+3
    logic [8:0] s1, in1_1, in1_2;
    logic       c1;

    assign in1_1 = {s0[9:2], pp[1][2]};
    assign in1_2 = {pp[5][6:2], pp[4][2], pp[3][2], pp[2][2], pp[0][3]};

    kogge_stone_adder #(.WIDTH(9)) ks1_i (
        .in1  (in1_1),
        .in2  (in1_2),
        .sum  (s1),
        .cout (c1)
    );

    // stage 3, weight k+4
    logic [6:0] s2, in2_1, in2_2;
    logic       c2;

    assign in2_1 = {s1[7:2], pp[1][3]};
    assign in2_2 = {pp[4][6:3], pp[3][3], pp[2][3], pp[0][4]};

    kogge_stone_adder #(.WIDTH(7)) ks2_i (
        .in1  (in2_1),
        .in2  (in2_2),
        .sum  (s2),
        .cout (c2)
    );

    // stage 4, weight k+5
    logic [4:0] s3, in3_1, in3_2;
    logic       c3;

    assign in3_1 = {s2[5:2], pp[1][4]};
    assign in3_2 = {pp[3][6:4], pp[2][4], pp[0][5]};

    kogge_stone_adder #(.WIDTH(5)) ks3_i (
        .in1  (in3_1),
        .in2  (in3_2),
        .sum  (s3),
        .cout (c3)
    );

    // stage 5, weight k+6
    logic [2:0] s4, in4_1, in4_2;
    logic       c4;

    assign in4_1 = {s3[3:2], pp[1][5]};
    assign in4_2 = {pp[2][6:5], pp[0][6]};

    kogge_stone_adder #(.WIDTH(3)) ks4_i (
        .in1  (in4_1),
        .in2  (in4_2),
        .sum  (s4),
        .cout (c4)
    );

    // stage 6, lone pair at weight 7
    logic s5, c5;

    assign s5 = pp[1][6] ^ pp[0][7];
    assign c5 = pp[1][6] & pp[0][7];

    // stage 7, top diagonal against the stage sums, weight k+8
    logic [5:0] s6, in6_1, in6_2;
    logic       c6;

    assign in6_1 = {pp[7][6], s0[10], s1[8], s2[6], s3[4], s4[2]};
    assign in6_2 = {pp[6][7], pp[5][7], pp[4][7], pp[3][7], pp[2][7], pp[1][7]};

    kogge_stone_adder #(.WIDTH(6)) ks6_i (
        .in1  (in6_1),
        .in2  (in6_2),
        .sum  (s6),
        .cout (c6)
    );

    // final carry-propagate add, weight k+1
    logic [13:0] s, in_1, in_2;
    logic        c;

    assign in_1 = {pp[7][7], c0, c1, c2, c3, c4, c5, s5,
                   s4[0], s3[0], s2[0], s1[0], s0[0], pp[1][0]};
    assign in_2 = {c6, s6, s4[1], s3[1], s2[1], s1[1], s0[1], pp[0][2], pp[0][1]};

    kogge_stone_adder #(.WIDTH(14)) ks_i (
        .in1  (in_1),
        .in2  (in_2),
        .sum  (s),
        .cout (c)
    );

    assign product_comb = {c, s, pp[0][0]}; // bit 0 needs no add

endmodule

// ==== hdl/mul_handshake.sv ====
`timescale 1ns/100ps

module mul_handshake
    import mul_types_pkg::*;
    import mul_hs_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req,
    input  operand_t a,
    input  operand_t b,
    input  product_t product_comb,
    output operand_t op_a,
    output operand_t op_b,
    output logic     ack,
    output product_t product
);

    hs_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= hs_idle;
            op_a    <= '0;
            op_b    <= '0;
            ack     <= 1'b0;
            product <= '0;
        end else begin
            case (state)
                hs_idle: begin
                    if (req) begin
                        op_a  <= a; // operands captured once
                        op_b  <= b;
                        state <= hs_compute;
                    end
                end
                hs_compute: begin
                    product <= product_comb; // tree settled on held operands
                    ack     <= 1'b1;
                    state   <= hs_done;
                end
                hs_done: begin
                    // hold ack and product until req drops
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= hs_release;
                    end
                end
                hs_release: begin
                    state <= hs_idle;
                end
                default: begin
                    state <= hs_idle;
                end
            endcase
        end
    end

endmodule

// ==== hdl/multiplier_8x8.sv ====
`timescale 1ns/100ps

module multiplier_8x8
    import mul_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req,
    input  operand_t a,
    input  operand_t b,
    output logic     ack,
    output product_t product
);

    operand_t op_a;
    operand_t op_b;
    product_t product_comb;

    mul_handshake hs_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .a            (a),
        .b            (b),
        .product_comb (product_comb),
        .op_a         (op_a),
        .op_b         (op_b),
        .ack          (ack),
        .product      (product)
    );

    // purely combinational, registered in hs_i
    partial_product_tree tree_i (
        .op_a         (op_a),
        .op_b         (op_b),
        .product_comb (product_comb)
    );

endmodule

// ==== verification/multiplier_asserts.sv ====
`timescale 1ns/100ps

module multiplier_asserts
    import mul_types_pkg::*;
(
    input logic     clk,
    input logic     arst_n,
    input logic     req,
    input operand_t a,
    input operand_t b,
    input logic     ack,
    input product_t product
);

    int fail_count = 0;

    // port-level view of the handshake
    logic     ack_q;      // high on the release edge
    logic     accept_q;   // high on the compute edge
    logic     accept_d2;
    logic     idle;
    logic     accept;
    operand_t a_d1, a_d2;
    operand_t b_d1, b_d2;
    product_t expected;

    assign idle     = !ack && !ack_q && !accept_q;
    assign accept   = req && idle;
    assign expected = product_t'(a_d2) * product_t'(b_d2); // operands from two edges back

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q     <= 1'b0;
            accept_q  <= 1'b0;
            accept_d2 <= 1'b0;
            a_d1      <= '0;
            a_d2      <= '0;
            b_d1      <= '0;
            b_d2      <= '0;
        end else begin
            ack_q     <= ack;
            accept_q  <= accept;
            accept_d2 <= accept_q;
            a_d1      <= a;
            a_d2      <= a_d1;
            b_d1      <= b;
            b_d2      <= b_d1;
        end
    end

    a_reset_clear: assert property (@(posedge clk)
        $rose(arst_n) |-> (!ack && product == '0))
        else begin
            $error("FAIL %0t: ack %0b product %0d after reset", $time, ack, product);
            fail_count++;
        end

    a_product_value: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> product == expected)
        else begin
            $error("FAIL %0t: product %0d, expected %0d", $time, product, expected);
            fail_count++;
        end

    // two edges from acceptance to ack, in both directions
    a_ack_latency: assert property (@(posedge clk) disable iff (!arst_n)
        accept_d2 |-> $rose(ack))
        else begin
            $error("FAIL %0t: ack not raised two edges after req", $time);
            fail_count++;
        end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> accept_d2)
        else begin
            $error("FAIL %0t: ack rose without an accepted req", $time);
            fail_count++;
        end

    a_product_stable: assert property (@(posedge clk) disable iff (!arst_n)
        ack && ack_q |-> $stable(product))
        else begin
            $error("FAIL %0t: product changed to %0d while ack high", $time, product);
            fail_count++;
        end

    a_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ack) |-> !$past(req))
        else begin
            $error("FAIL %0t: ack fell while req was high", $time);
            fail_count++;
        end

    a_ack_held: assert property (@(posedge clk) disable iff (!arst_n)
        $past(ack) && $past(req) |-> ack)
        else begin
            $error("FAIL %0t: ack dropped while req held", $time);
            fail_count++;
        end

endmodule

// ==== verification/tb_multiplier.sv ====
`timescale 1ns/100ps

module tb_multiplier
    import mul_types_pkg::*;
();

    localparam int clk_period      = 100;
    localparam int reset_cycles    = 8;
    localparam int num_random      = 200;
    localparam int num_directed    = 4 + 2 * operand_w;
    localparam int num_txn         = num_directed + num_random;
    localparam int hs_timeout      = 10; // cycles per handshake phase
    localparam int watchdog_cycles = num_txn * 10 + reset_cycles + 50;

    logic     clk;
    logic     arst_n;
    logic     req;
    operand_t a;
    operand_t b;
    logic     ack;
    product_t product;

    int hang_errors;

    multiplier_8x8 dut_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .a       (a),
        .b       (b),
        .ack     (ack),
        .product (product)
    );

    bind multiplier_8x8 multiplier_asserts asserts_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .a       (a),
        .b       (b),
        .ack     (ack),
        .product (product)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic operand_t random_operand();
        return operand_t'($urandom_range(255, 0));
    endfunction

    // one four-phase transaction, entered and left on a falling edge
    task automatic run_transaction(
        input operand_t    op1,
        input operand_t    op2,
        input int unsigned hold
    );
        int waited;
        a      = op1;
        b      = op2;
        req    = 1'b1;
        waited = 0;
        while (!ack && waited < hs_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            $display("handshake hang at %0t: ack did not rise within %0d cycles",
                     $time, hs_timeout);
            hang_errors++;
        end
        // req held, operands move and must be ignored
        repeat (hold) begin
            @(negedge clk);
            a = random_operand();
            b = random_operand();
        end
        req    = 1'b0;
        waited = 0;
        while (ack && waited < hs_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            $display("handshake hang at %0t: ack did not fall within %0d cycles",
                     $time, hs_timeout);
            hang_errors++;
        end
    endtask

    task automatic report_and_finish();
        int assert_errors;
        assert_errors = dut_i.asserts_i.fail_count;
        $display("hang errors: %0d, assertion failures: %0d", hang_errors, assert_errors);
        if (hang_errors == 0 && assert_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'hf7d5));
        hang_errors = 0;
        req         = 1'b0;
        a           = '0;
        b           = '0;
        arst_n      = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // corner operands
        run_transaction(8'h00, 8'h00, 0);
        run_transaction(8'h00, 8'hff, 0);
        run_transaction(8'hff, 8'h00, 0);
        run_transaction(8'hff, 8'hff, 0);

        for (int i = 0; i < operand_w; i++) begin
            run_transaction(operand_t'(1 << i), random_operand(), 0); // single bit in a
            run_transaction(random_operand(), operand_t'(1 << i), 0); // single bit in b
        end

        // random pairs with back-pressure of up to three cycles
        for (int n = 0; n < num_random; n++) begin
            run_transaction(random_operand(), random_operand(), $urandom_range(3, 0));
        end

        repeat (4) @(negedge clk);
        report_and_finish();
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
        hang_errors++;
        report_and_finish();
    end

endmodule

// ==== tb.f ====
hdl/mul_types_pkg.sv
hdl/mul_hs_pkg.sv
hdl/kogge_stone_adder.sv
hdl/partial_product_tree.sv
hdl/mul_handshake.sv
hdl/multiplier_8x8.sv
verification/multiplier_asserts.sv
verification/tb_multiplier.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_multiplier
FILELIST := tb.f
RUN_ARGS := +verilator+error+limit+1000

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST) Makefile
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
